// File: source/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// core and bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// direct-mapped, one word per line
`define LSU_IDX_W 6

// cacheable window, base inclusive, limit exclusive
`define LSU_CACHE_BASE 32'h8000_0000
`define LSU_CACHE_LIMIT 32'h8000_4000

`endif

// File: source/lsu_pkg.sv
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

  // bit 3 marks a store, low bits give size and sign
  typedef enum logic [3:0] {
    OP_LB  = 4'b0000,
    OP_LH  = 4'b0001,
    OP_LW  = 4'b0010,
    OP_LBU = 4'b0100,
    OP_LHU = 4'b0101,
    OP_SB  = 4'b1000,
    OP_SH  = 4'b1001,
    OP_SW  = 4'b1010
  } lsu_op_e;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MEM_RD,
    MEM_WR,
    RESP
  } lsu_state_e;

  typedef struct packed {
    lsu_op_e                 op;
    logic [`LSU_ADDR_W-1:0]  addr;
    logic [`LSU_DATA_W-1:0]  wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0]  rdata;
    logic                    hit;
  } lsu_rsp_t;

  // word address, byte offset dropped
  typedef struct packed {
    logic [`LSU_ADDR_W-3:0]  addr;
    logic                    we;
    logic [3:0]              wstrb;
    logic [`LSU_DATA_W-1:0]  wdata;
  } mem_req_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0]  rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: source/lsu_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_align import lsu_pkg::*; (
  input  lsu_op_e                 op_i,
  input  logic [1:0]              offset_i,
  input  logic [`LSU_DATA_W-1:0]  wdata_i,
  input  logic [`LSU_DATA_W-1:0]  word_i,
  output logic [3:0]              wstrb_o,
  output logic [`LSU_DATA_W-1:0]  wdata_o,
  output logic [`LSU_DATA_W-1:0]  load_data_o
);

  logic [`LSU_DATA_W-1:0] shifted;

  // store side, data copied into every lane
  always_comb
  begin
    case (op_i)
      OP_SB:
      begin
        wstrb_o = 4'b0001 << offset_i;
        wdata_o = {4{wdata_i[7:0]}};
      end
      OP_SH:
      begin
        wstrb_o = 4'b0011 << offset_i;
        wdata_o = {2{wdata_i[15:0]}};
      end
      OP_SW:
      begin
        wstrb_o = 4'b1111;
        wdata_o = wdata_i;
      end
      default:
      begin
        wstrb_o = 4'b0000;
        wdata_o = wdata_i;
      end
    endcase
  end

  // load side
  assign shifted = word_i >> {offset_i, 3'b000};

  always_comb
  begin
    case (op_i)
      OP_LB:   load_data_o = {{24{shifted[7]}}, shifted[7:0]};
      OP_LBU:  load_data_o = {24'b0, shifted[7:0]};
      OP_LH:   load_data_o = {{16{shifted[15]}}, shifted[15:0]};
      OP_LHU:  load_data_o = {16'b0, shifted[15:0]};
      OP_LW:   load_data_o = shifted;
      default: load_data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/l1d_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module l1d_cache (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    lookup_i,
  input  logic [`LSU_ADDR_W-3:0]  lookup_addr_i,
  input  logic                    fill_i,
  input  logic [`LSU_ADDR_W-3:0]  fill_addr_i,
  input  logic [`LSU_DATA_W-1:0]  fill_word_i,
  input  logic                    inval_i,
  input  logic [`LSU_ADDR_W-3:0]  inval_addr_i,
  output logic                    hit_o,
  output logic [`LSU_DATA_W-1:0]  hit_word_o
);

  localparam int IDX_W = `LSU_IDX_W;
  localparam int TAG_W = `LSU_ADDR_W - IDX_W - 2;
  localparam int LINES = 1 << IDX_W;

  logic [TAG_W-1:0]       tag_q  [LINES];
  logic [`LSU_DATA_W-1:0] data_q [LINES];
  logic [LINES-1:0]       valid_q;

  logic                   hit_q;
  logic [`LSU_DATA_W-1:0] word_q;

  logic [IDX_W-1:0]       lk_idx;
  logic [TAG_W-1:0]       lk_tag;
  logic [IDX_W-1:0]       fill_idx;
  logic [TAG_W-1:0]       fill_tag;
  logic [IDX_W-1:0]       inval_idx;
  logic [`LSU_ADDR_W-1:0] fill_byte_addr;
  logic                   fill_en;

  assign lk_idx    = lookup_addr_i[IDX_W-1:0];
  assign lk_tag    = lookup_addr_i[`LSU_ADDR_W-3:IDX_W];
  assign fill_idx  = fill_addr_i[IDX_W-1:0];
  assign fill_tag  = fill_addr_i[`LSU_ADDR_W-3:IDX_W];
  assign inval_idx = inval_addr_i[IDX_W-1:0];

  // only words inside the window are ever allocated
  assign fill_byte_addr = {fill_addr_i, 2'b00};
  assign fill_en = fill_i
                && (fill_byte_addr >= `LSU_CACHE_BASE)
                && (fill_byte_addr < `LSU_CACHE_LIMIT);

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      valid_q <= '0;
      hit_q   <= 1'b0;
    end
    else
    begin
      hit_q <= lookup_i && valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
      if (fill_en)
        valid_q[fill_idx] <= 1'b1;
      // invalidate wins over a fill to the same line
      if (inval_i)
        valid_q[inval_idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (lookup_i)
      word_q <= data_q[lk_idx];
    if (fill_en)
    begin
      tag_q[fill_idx]  <= fill_tag;
      data_q[fill_idx] <= fill_word_i;
    end
  end

  assign hit_o      = hit_q;
  assign hit_word_o = word_q;

endmodule

`default_nettype wire

// File: source/lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_ctrl import lsu_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  lsu_req_t                req_i,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output lsu_rsp_t                rsp_o,
  output logic                    mem_req_valid_o,
  input  logic                    mem_req_ready_i,
  output mem_req_t                mem_req_o,
  input  logic                    mem_rsp_valid_i,
  input  mem_rsp_t                mem_rsp_i,
  output logic                    lookup_o,
  output logic [`LSU_ADDR_W-3:0]  lookup_addr_o,
  output logic                    fill_o,
  output logic [`LSU_ADDR_W-3:0]  fill_addr_o,
  output logic [`LSU_DATA_W-1:0]  fill_word_o,
  output logic                    inval_o,
  output logic [`LSU_ADDR_W-3:0]  inval_addr_o,
  input  logic                    hit_i,
  input  logic [`LSU_DATA_W-1:0]  hit_word_i
);

  lsu_state_e state_q;
  lsu_req_t   req_q;
  lsu_rsp_t   rsp_q;
  logic       sent_q;

  logic                   accept;
  logic                   req_is_store;
  logic                   op_is_store;
  logic [3:0]             wstrb;
  logic [`LSU_DATA_W-1:0] wdata_placed;
  logic [`LSU_DATA_W-1:0] raw_word;
  logic [`LSU_DATA_W-1:0] load_data;

  assign req_ready_o  = (state_q == IDLE);
  assign accept       = req_valid_i && req_ready_o;
  assign req_is_store = req_i.op[3];
  assign op_is_store  = req_q.op[3];

  // hit word while looking up, bus word otherwise
  assign raw_word = (state_q == LOOKUP) ? hit_word_i : mem_rsp_i.rdata;

  lsu_align u_align (
    .op_i        (req_q.op),
    .offset_i    (req_q.addr[1:0]),
    .wdata_i     (req_q.wdata),
    .word_i      (raw_word),
    .wstrb_o     (wstrb),
    .wdata_o     (wdata_placed),
    .load_data_o (load_data)
  );

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      state_q <= IDLE;
      sent_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
          if (accept)
            state_q <= LOOKUP;
        LOOKUP:
          if (op_is_store)
            state_q <= MEM_WR;
          else if (hit_i)
            state_q <= RESP;
          else
            state_q <= MEM_RD;
        MEM_RD, MEM_WR:
        begin
          if (mem_req_valid_o && mem_req_ready_i)
            sent_q <= 1'b1;
          if (sent_q && mem_rsp_valid_i)
          begin
            sent_q  <= 1'b0;
            state_q <= RESP;
          end
        end
        RESP:
          if (rsp_ready_i)
            state_q <= IDLE;
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk)
  begin
    if (accept)
      req_q <= req_i;
    if (state_q == LOOKUP && !op_is_store && hit_i)
    begin
      rsp_q.rdata <= load_data;
      rsp_q.hit   <= 1'b1;
    end
    else if (sent_q && mem_rsp_valid_i)
    begin
      rsp_q.rdata <= (state_q == MEM_RD) ? load_data : '0;
      rsp_q.hit   <= 1'b0;
    end
  end

  assign rsp_valid_o = (state_q == RESP);
  assign rsp_o       = rsp_q;

  // one bus transaction, held until taken
  assign mem_req_valid_o = (state_q == MEM_RD || state_q == MEM_WR) && !sent_q;
  assign mem_req_o.addr  = req_q.addr[`LSU_ADDR_W-1:2];
  assign mem_req_o.we    = (state_q == MEM_WR);
  assign mem_req_o.wstrb = (state_q == MEM_WR) ? wstrb : 4'b1111;
  assign mem_req_o.wdata = wdata_placed;

  assign lookup_o      = accept && !req_is_store;
  assign lookup_addr_o = req_i.addr[`LSU_ADDR_W-1:2];

  assign fill_o      = (state_q == MEM_RD) && sent_q && mem_rsp_valid_i;
  assign fill_addr_o = req_q.addr[`LSU_ADDR_W-1:2];
  assign fill_word_o = mem_rsp_i.rdata;

  // line dropped at the edge after acceptance
  assign inval_o      = (state_q == LOOKUP) && op_is_store;
  assign inval_addr_o = req_q.addr[`LSU_ADDR_W-1:2];

endmodule

`default_nettype wire

// File: source/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_top import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  lsu_req_t  req_i,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output lsu_rsp_t  rsp_o,
  output logic      mem_req_valid_o,
  input  logic      mem_req_ready_i,
  output mem_req_t  mem_req_o,
  input  logic      mem_rsp_valid_i,
  input  mem_rsp_t  mem_rsp_i
);

  logic                   lookup;
  logic [`LSU_ADDR_W-3:0] lookup_addr;
  logic                   fill;
  logic [`LSU_ADDR_W-3:0] fill_addr;
  logic [`LSU_DATA_W-1:0] fill_word;
  logic                   inval;
  logic [`LSU_ADDR_W-3:0] inval_addr;
  logic                   hit;
  logic [`LSU_DATA_W-1:0] hit_word;

  lsu_ctrl u_ctrl (
    .clk             (clk),
    .rst_i           (rst_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_i           (req_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_o           (rsp_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i),
    .lookup_o        (lookup),
    .lookup_addr_o   (lookup_addr),
    .fill_o          (fill),
    .fill_addr_o     (fill_addr),
    .fill_word_o     (fill_word),
    .inval_o         (inval),
    .inval_addr_o    (inval_addr),
    .hit_i           (hit),
    .hit_word_i      (hit_word)
  );

  l1d_cache u_cache (
    .clk           (clk),
    .rst_i         (rst_i),
    .lookup_i      (lookup),
    .lookup_addr_i (lookup_addr),
    .fill_i        (fill),
    .fill_addr_i   (fill_addr),
    .fill_word_i   (fill_word),
    .inval_i       (inval),
    .inval_addr_i  (inval_addr),
    .hit_o         (hit),
    .hit_word_o    (hit_word)
  );

endmodule

`default_nettype wire

// File: tb/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_tb import lsu_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int WAIT_LIMIT   = 64;
  localparam logic [31:0] MEM_PATTERN = 32'hC3A5_FE81;
  localparam logic [31:0] RAND_SEED   = 32'h95e1_c3af;

  logic     clk;
  logic     rst_i;
  logic     req_valid_i;
  logic     req_ready_o;
  lsu_req_t req_i;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  lsu_rsp_t rsp_o;
  logic     mem_req_valid_o;
  logic     mem_req_ready_i = 1'b0;
  mem_req_t mem_req_o;
  logic     mem_rsp_valid_i = 1'b0;
  mem_rsp_t mem_rsp_i = '0;

  lsu_req_t stim_req [$];
  lsu_rsp_t stim_rsp [$];
  int       n_tests = 0;
  logic     stim_loaded = 1'b0;
  int       errors = 0;
  int       pass_count = 0;
  int       fail_count = 0;

  // memory model state
  logic [`LSU_DATA_W-1:0] mem_q [logic [`LSU_ADDR_W-3:0]];
  logic                   bus_busy = 1'b0;
  int                     rsp_delay = 0;
  int                     ready_wait = 0;
  logic [`LSU_DATA_W-1:0] bus_word;
  int                     bus_count = 0;
  mem_req_t               last_mem_req;
  mem_req_t               stalled_req;
  logic                   stalled = 1'b0;

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  lsu_top dut_i (
    .clk             (clk),
    .rst_i           (rst_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_i           (req_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_o           (rsp_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i)
  );

  // untouched words follow the address
  function automatic logic [31:0] mem_read(input logic [`LSU_ADDR_W-3:0] waddr);
    if (mem_q.exists(waddr))
      return mem_q[waddr];
    return {waddr, 2'b00} ^ MEM_PATTERN;
  endfunction

  function automatic mem_req_t expected_mem_req(input lsu_req_t req);
    mem_req_t m;
    int       size;
    size = 4;
    if (req.op == OP_SB)
      size = 1;
    else if (req.op == OP_SH)
      size = 2;
    m.addr  = req.addr[`LSU_ADDR_W-1:2];
    m.we    = (req.op == OP_SB) || (req.op == OP_SH) || (req.op == OP_SW);
    m.wstrb = '0;
    m.wdata = '0;
    for (int b = 0; b < 4; b++)
    begin
      // lane b carries byte (b mod size) of the store data
      m.wdata[8*b +: 8] = req.wdata[8*(b % size) +: 8];
      if (!m.we || (b >= req.addr[1:0] && b < req.addr[1:0] + size))
        m.wstrb[b] = 1'b1;
    end
    return m;
  endfunction

  task automatic check_rsp(input string name, input lsu_rsp_t exp, input lsu_rsp_t act);
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s expected rdata=%h hit=%b got rdata=%h hit=%b",
               $time, name, exp.rdata, exp.hit, act.rdata, act.hit);
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
    string exp_s;
    string act_s;
    if (act !== exp)
    begin
      errors++;
      exp_s = $sformatf("addr=%h we=%b wstrb=%b wdata=%h",
                        exp.addr, exp.we, exp.wstrb, exp.wdata);
      act_s = $sformatf("addr=%h we=%b wstrb=%b wdata=%h",
                        act.addr, act.we, act.wstrb, act.wdata);
      $display("[FAIL] %0t %s expected %s got %s", $time, name, exp_s, act_s);
    end
  endtask

  task automatic read_stim();
    int          fd;
    int          n;
    string       line;
    logic [3:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        hit;
    lsu_req_t    req;
    lsu_rsp_t    rsp;
    fd = $fopen("tb/lsu_stim.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open the stimulus file tb/lsu_stim.txt");
      return;
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && line[0] != "#")
      begin
        n = $sscanf(line, "%h %h %h %h %h", op, addr, wdata, rdata, hit);
        if (n == 5)
        begin
          req.op    = lsu_op_e'(op);
          req.addr  = addr;
          req.wdata = wdata;
          rsp.rdata = rdata;
          rsp.hit   = hit;
          stim_req.push_back(req);
          stim_rsp.push_back(rsp);
        end
      end
    end
    $fclose(fd);
    n_tests = stim_req.size();
  endtask

  // one access from request to accepted response
  task automatic run_access(input lsu_req_t req, input lsu_rsp_t exp);
    lsu_rsp_t held;
    int       waited;
    int       stall;
    int       bus_before;
    bus_before = bus_count;
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_i       <= req;
    waited = 0;
    @(posedge clk);
    while (!req_ready_o && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    req_valid_i <= 1'b0;
    if (!req_ready_o)
    begin
      errors++;
      $display("%0t: request was never accepted", $time);
      return;
    end
    // edges counted from the accepting edge
    waited = 1;
    @(posedge clk);
    while (!rsp_valid_o && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (!rsp_valid_o)
    begin
      errors++;
      $display("%0t: response did not arrive within %0d cycles", $time, WAIT_LIMIT);
      return;
    end
    if (exp.hit && waited != 2)
    begin
      errors++;
      $display("%0t: cache hit answered after %0d cycles instead of 2", $time, waited);
    end
    held  = rsp_o;
    stall = $urandom_range(0, 2);
    repeat (stall)
    begin
      @(posedge clk);
      if (!rsp_valid_o || req_ready_o)
      begin
        errors++;
        $display("%0t: handshake changed while the response was held back", $time);
      end
      check_rsp("rsp_o", held, rsp_o);
    end
    rsp_ready_i <= 1'b1;
    @(posedge clk);
    rsp_ready_i <= 1'b0;
    check_rsp("rsp_o", exp, rsp_o);
    if (exp.hit && bus_count != bus_before)
    begin
      errors++;
      $display("%0t: load hit still issued a bus request", $time);
    end
    else if (!exp.hit && bus_count != bus_before + 1)
    begin
      errors++;
      $display("%0t: expected one bus transfer, saw %0d", $time, bus_count - bus_before);
    end
    else if (!exp.hit)
      check_mem_req("mem_req_o", expected_mem_req(req), last_mem_req);
  endtask

  // memory model with random ready and reply delays
  always @(posedge clk)
  begin
    mem_rsp_valid_i <= 1'b0;
    if (rst_i)
    begin
      mem_req_ready_i <= 1'b0;
      bus_busy   = 1'b0;
      stalled    = 1'b0;
      ready_wait = $urandom_range(0, 3);
    end
    else if (bus_busy)
    begin
      if (rsp_delay == 0)
      begin
        mem_rsp_valid_i <= 1'b1;
        mem_rsp_i.rdata <= bus_word;
        bus_busy = 1'b0;
      end
      else
        rsp_delay--;
    end
    else if (mem_req_valid_o && mem_req_ready_i)
    begin
      // accepted request must match the one that waited
      if (stalled)
        check_mem_req("mem_req_o", stalled_req, mem_req_o);
      stalled = 1'b0;
      bus_count++;
      last_mem_req = mem_req_o;
      bus_word = mem_read(mem_req_o.addr);
      if (mem_req_o.we)
      begin
        for (int b = 0; b < 4; b++)
          if (mem_req_o.wstrb[b])
            bus_word[8*b +: 8] = mem_req_o.wdata[8*b +: 8];
        mem_q[mem_req_o.addr] = bus_word;
        bus_word = '0;
      end
      mem_req_ready_i <= 1'b0;
      bus_busy   = 1'b1;
      rsp_delay  = $urandom_range(0, 3);
      ready_wait = $urandom_range(0, 3);
    end
    else if (mem_req_valid_o)
    begin
      // request held steady while ready is low
      if (stalled)
        check_mem_req("mem_req_o", stalled_req, mem_req_o);
      stalled     = 1'b1;
      stalled_req = mem_req_o;
      if (ready_wait == 0)
        mem_req_ready_i <= 1'b1;
      else
        ready_wait--;
    end
  end

  initial
  begin
    int      errs_before;
    lsu_op_e cur_op;
    void'($urandom(RAND_SEED));
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    read_stim();
    stim_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
    if (!req_ready_o || rsp_valid_o || mem_req_valid_o)
    begin
      errors++;
      $display("outputs were not at their reset values when reset was released");
    end
    for (int i = 0; i < n_tests; i++)
    begin
      errs_before = errors;
      cur_op      = stim_req[i].op;
      run_access(stim_req[i], stim_rsp[i]);
      if (errors == errs_before)
        pass_count++;
      else
        fail_count++;
      $display("test %0d %s addr %h: %s", i, cur_op.name(), stim_req[i].addr,
               (errors == errs_before) ? "ok" : "error");
    end
    $display("summary: %0d tests passed, %0d failed, %0d errors",
             pass_count, fail_count, errors);
    if (errors == 0 && fail_count == 0 && n_tests > 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // watchdog, twenty cycles per access
  initial
  begin
    wait (stim_loaded);
    #((n_tests * 20 + 2 * RESET_CYCLES) * CLK_PERIOD);
    $display("watchdog expired, the accesses did not finish in time");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: lsu_top.f
+incdir+source
source/lsu_pkg.sv
source/lsu_align.sv
source/l1d_cache.sv
source/lsu_ctrl.sv
source/lsu_top.sv
tb/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= lsu_top.f
TB_TOP    ?= lsu_tb
RTL_TOP   ?= lsu_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= TB FAILED
PASS_MSG  ?= TB PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/lsu_stim.txt
# op addr wdata exp_rdata exp_hit, all hex; op is the lsu_op_e code
# (0 LB, 1 LH, 2 LW, 4 LBU, 5 LHU, 8 SB, 9 SH, a SW); stores expect 00000000 0
2 80000100 00000000 43a5ff81 0
2 80000100 00000000 43a5ff81 1
0 80000100 00000000 ffffff81 1
0 80000101 00000000 ffffffff 1
0 80000102 00000000 ffffffa5 1
0 80000103 00000000 00000043 1
4 80000100 00000000 00000081 1
4 80000102 00000000 000000a5 1
1 80000100 00000000 ffffff81 1
1 80000102 00000000 000043a5 1
5 80000100 00000000 0000ff81 1
5 80000102 00000000 000043a5 1
0 00002001 00000000 ffffffde 0
4 00002003 00000000 000000c3 0
1 00002002 00000000 ffffc3a5 0
2 00002000 00000000 c3a5de81 0
2 00002000 00000000 c3a5de81 0
8 80000101 00000012 00000000 0
2 80000100 00000000 43a51281 0
2 80000100 00000000 43a51281 1
9 80000102 0000beef 00000000 0
1 80000102 00000000 ffffbeef 0
4 80000100 00000000 00000081 1
a 80000100 01234567 00000000 0
5 80000102 00000000 00000123 0
0 80003fff 00000000 00000043 0
1 80003ffc 00000000 ffffc17d 1
2 80004000 00000000 43a5be81 0
2 80004000 00000000 43a5be81 0
2 80000100 00000000 01234567 1
8 00002000 000000ab 00000000 0
4 00002000 00000000 000000ab 0
9 80000200 00007654 00000000 0
2 80000200 00000000 43a57654 0
2 80000200 00000000 43a57654 1
2 80000100 00000000 01234567 0
8 80003ffe 0000005a 00000000 0
2 80003ffc 00000000 435ac17d 0
